// ==== src/decim_pkg.sv ====
// Fractional decimator definitions
`default_nettype none

package decim_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Fixed-point formats
    ////////////////////////////////////////////////////////////////////////////

    // Samples are S16.15 and coefficients S20.18
    localparam int DATA_WIDTH  = 16;
    localparam int DATA_FRAC   = 15;
    localparam int COEFF_WIDTH = 20;
    localparam int COEFF_FRAC  = 18;
    localparam int PHASE_TAPS  = 8;

    localparam int PROD_WIDTH  = DATA_WIDTH + COEFF_WIDTH;
    localparam int ACC_WIDTH   = PROD_WIDTH + $clog2(PHASE_TAPS);
    localparam int ACC_FRAC    = DATA_FRAC + COEFF_FRAC;
    localparam int ROUND_SHIFT = ACC_FRAC - DATA_FRAC;

    // Levels of the pairwise adder tree
    localparam int TREE_DEPTH  = $clog2(PHASE_TAPS);

    typedef logic signed [DATA_WIDTH-1:0]  sample_t;
    typedef logic signed [COEFF_WIDTH-1:0] coeff_t;
    typedef logic signed [ACC_WIDTH-1:0]   acc_t;

    // Saturation limits of the output format
    localparam sample_t SAMPLE_MAX = {1'b0, {(DATA_WIDTH - 1){1'b1}}};
    localparam sample_t SAMPLE_MIN = {1'b1, {(DATA_WIDTH - 1){1'b0}}};

    ////////////////////////////////////////////////////////////////////////////
    // Phase control
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        PH_SKIP = 2'd0,
        PH_A    = 2'd1,
        PH_B    = 2'd2
    } decim_phase_e;

    typedef struct packed {
        logic         phase_hit;
        decim_phase_e phase;
    } decim_ctrl_t;

    ////////////////////////////////////////////////////////////////////////////
    // Coefficient tables
    ////////////////////////////////////////////////////////////////////////////

    // Listed from tap 7 down to tap 0, gain of 1.0 per phase
    localparam coeff_t [PHASE_TAPS-1:0] COEFF_PHASE_A = {
        -20'sd8192,  -20'sd8192,  -20'sd32768, 20'sd98304,
        20'sd131072, 20'sd65536,  -20'sd16384, 20'sd32768
    };

    localparam coeff_t [PHASE_TAPS-1:0] COEFF_PHASE_B = {
        20'sd8192,   -20'sd32768, -20'sd16384, 20'sd65536,
        20'sd131072, 20'sd98304,  20'sd16384,  -20'sd8192
    };

endpackage

`default_nettype wire

// ==== src/decim_phase_fsm.sv ====
// Decimator phase sequencer
`default_nettype none

module decim_phase_fsm import decim_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        valid_in,
    output decim_ctrl_t ctrl
);

    decim_phase_e state;
    decim_phase_e state_next;

    // One step per accepted sample
    always_comb begin
        state_next = state;
        if (valid_in) begin
            case (state)
                PH_SKIP: state_next = PH_A;
                PH_A:    state_next = PH_B;
                default: state_next = PH_SKIP;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= PH_SKIP;
        end else begin
            state <= state_next;
        end
    end

    // Two of every three samples produce a result
    always_comb begin
        ctrl.phase     = state;
        ctrl.phase_hit = (state == PH_A) || (state == PH_B);
    end

endmodule

`default_nettype wire

// ==== src/tap_delay_line.sv ====
// Sample delay line
`default_nettype none

module tap_delay_line import decim_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     valid_in,
    input  sample_t                  filter_in,
    output sample_t [PHASE_TAPS-1:0] taps
);

    // Tap zero holds the newest stored sample
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            taps <= '0;
        end else if (valid_in) begin
            taps <= {taps[PHASE_TAPS-2:0], filter_in};
        end
    end

endmodule

`default_nettype wire

// ==== src/polyphase_mac.sv ====
// Polyphase multiply and adder tree
`default_nettype none

module polyphase_mac import decim_pkg::*; (
    input  sample_t [PHASE_TAPS-1:0] taps,
    input  decim_ctrl_t              ctrl,
    output acc_t                     acc
);

    coeff_t [PHASE_TAPS-1:0]      coeff_sel;
    logic signed [PROD_WIDTH-1:0] prod [PHASE_TAPS];

    // Level zero holds the extended products, the last level the sum
    acc_t node [TREE_DEPTH+1][PHASE_TAPS];

    // Phase B has its own table, every other phase uses table A
    assign coeff_sel = (ctrl.phase == PH_B) ? COEFF_PHASE_B : COEFF_PHASE_A;

    ////////////////////////////////////////////////////////////////////////////
    // Tap products
    ////////////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < PHASE_TAPS; i++) begin : g_tap
        assign prod[i] = $signed(taps[i]) * $signed(coeff_sel[i]);

        assign node[0][i] = {{(ACC_WIDTH - PROD_WIDTH){prod[i][PROD_WIDTH-1]}}, prod[i]};
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pairwise adder tree
    ////////////////////////////////////////////////////////////////////////////

    for (genvar lvl = 0; lvl < TREE_DEPTH; lvl++) begin : g_level
        localparam int IN_CNT  = (PHASE_TAPS + (1 << lvl) - 1) >> lvl;
        localparam int OUT_CNT = (IN_CNT >> 1) + (IN_CNT & 1);

        for (genvar n = 0; n < PHASE_TAPS; n++) begin : g_node
            if (n >= OUT_CNT) begin : g_unused
                assign node[lvl+1][n] = '0;
            end else if ((2 * n + 1) >= IN_CNT) begin : g_odd
                // Odd node passes straight to the next level
                assign node[lvl+1][n] = node[lvl][2*n];
            end else begin : g_pair
                assign node[lvl+1][n] = node[lvl][2*n] + node[lvl][2*n+1];
            end
        end
    end

    assign acc = node[TREE_DEPTH][0];

endmodule

`default_nettype wire

// ==== src/output_quantizer.sv ====
// Output rounding and saturation
`default_nettype none

module output_quantizer import decim_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    valid_in,
    input  logic    bypass,
    input  sample_t filter_in,
    input  logic    phase_hit,
    input  acc_t    acc,
    output sample_t filter_out,
    output logic    overflow,
    output logic    underflow,
    output logic    valid_out
);

    acc_t    rounded;
    sample_t sat_value;
    logic    sat_high;
    logic    sat_low;

    // Round half up to S16.15, then clamp to the sample range
    always_comb begin
        rounded   = (acc + (acc_t'(1) <<< (ROUND_SHIFT - 1))) >>> ROUND_SHIFT;
        sat_high  = 1'b0;
        sat_low   = 1'b0;
        sat_value = rounded[DATA_WIDTH-1:0];
        if (rounded > acc_t'(SAMPLE_MAX)) begin
            sat_value = SAMPLE_MAX;
            sat_high  = 1'b1;
        end else if (rounded < acc_t'(SAMPLE_MIN)) begin
            sat_value = SAMPLE_MIN;
            sat_low   = 1'b1;
        end
    end

    // Outputs hold between results
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            filter_out <= '0;
            overflow   <= 1'b0;
            underflow  <= 1'b0;
            valid_out  <= 1'b0;
        end else if (valid_in && bypass) begin
            filter_out <= filter_in;
            overflow   <= 1'b0;
            underflow  <= 1'b0;
            valid_out  <= 1'b1;
        end else if (valid_in && phase_hit) begin
            filter_out <= sat_value;
            overflow   <= sat_high;
            underflow  <= sat_low;
            valid_out  <= 1'b1;
        end else begin
            valid_out  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== src/fractional_decimator.sv ====
// Fractional decimator top level
`default_nettype none

module fractional_decimator import decim_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    valid_in,
    input  logic    bypass,
    input  sample_t filter_in,
    output sample_t filter_out,
    output logic    overflow,
    output logic    underflow,
    output logic    valid_out
);

    decim_ctrl_t              ctrl;
    sample_t [PHASE_TAPS-1:0] taps;
    acc_t                     acc;

    decim_phase_fsm u_phase_fsm (
        .clk      (clk),
        .rst_n    (rst_n),
        .valid_in (valid_in),
        .ctrl     (ctrl)
    );

    tap_delay_line u_delay_line (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (valid_in),
        .filter_in (filter_in),
        .taps      (taps)
    );

    polyphase_mac u_mac (
        .taps (taps),
        .ctrl (ctrl),
        .acc  (acc)
    );

    output_quantizer u_quantizer (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid_in   (valid_in),
        .bypass     (bypass),
        .filter_in  (filter_in),
        .phase_hit  (ctrl.phase_hit),
        .acc        (acc),
        .filter_out (filter_out),
        .overflow   (overflow),
        .underflow  (underflow),
        .valid_out  (valid_out)
    );

endmodule

`default_nettype wire

// ==== dv/fractional_decimator_tb.sv ====
// Fractional decimator testbench
`default_nettype none

module fractional_decimator_tb import decim_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 4;
    localparam int RESET_LEN    = RESET_CYCLES + 2;

    // Driven cycles per test, the resets included
    localparam int TEST_CYCLES = (RESET_LEN + 2) + 6 * RESET_LEN + (30 + 60 + 2) + (15 + 1)
                               + (60 + 1) + 2 * (11 + 1) + (12 + 20 + 1);
    localparam int MARGIN      = 200;

    logic    clk;
    logic    rst_n;
    logic    valid_in;
    logic    bypass;
    sample_t filter_in;
    sample_t filter_out;
    logic    overflow;
    logic    underflow;
    logic    valid_out;

    // Reference model state
    int          hist [PHASE_TAPS];
    int          phase_cnt;
    logic        exp_valid;
    sample_t     exp_value;
    logic        exp_ovf;
    logic        exp_unf;
    int          out_count;
    int          error_count;
    int          check_count;
    logic [31:0] rng_state;
    string       test_name;

    fractional_decimator u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid_in   (valid_in),
        .bypass     (bypass),
        .filter_in  (filter_in),
        .filter_out (filter_out),
        .overflow   (overflow),
        .underflow  (underflow),
        .valid_out  (valid_out)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        #((TEST_CYCLES + MARGIN) * CLK_PERIOD);
        $display("Watchdog timeout: the tests did not finish in time");
        $display("Errors found");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string what, input longint expected, input longint actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("Error [%s] %s: expected %0d, actual %0d", test_name, what, expected, actual);
        end
    endtask

    // Dot product of the stored history with one phase table, then round and clamp
    task automatic model_result(input int phase, output sample_t value, output logic ovf,
                                output logic unf);
        longint acc;
        longint rounded;
        longint c;
        acc = 0;
        for (int k = 0; k < PHASE_TAPS; k++) begin
            c   = (phase == 1) ? longint'($signed(COEFF_PHASE_A[k]))
                               : longint'($signed(COEFF_PHASE_B[k]));
            acc = acc + longint'(hist[k]) * c;
        end
        rounded = (acc + (longint'(1) << 17)) >>> 18;
        ovf     = 1'b0;
        unf     = 1'b0;
        if (rounded > 32767) begin
            value = 16'sd32767;
            ovf   = 1'b1;
        end else if (rounded < -32768) begin
            value = -16'sd32768;
            unf   = 1'b1;
        end else begin
            value = sample_t'(rounded);
        end
    endtask

    task automatic model_update(input logic v, input logic b, input sample_t d);
        exp_valid = 1'b0;
        if (v) begin
            if (b) begin
                exp_value = d;
                exp_ovf   = 1'b0;
                exp_unf   = 1'b0;
                exp_valid = 1'b1;
            end else if (phase_cnt != 0) begin
                model_result(phase_cnt, exp_value, exp_ovf, exp_unf);
                exp_valid = 1'b1;
            end
            for (int k = PHASE_TAPS - 1; k > 0; k--) begin
                hist[k] = hist[k-1];
            end
            hist[0]   = d;
            phase_cnt = (phase_cnt + 1) % 3;
        end
    endtask

    // Outputs of the previous drive are checked at the falling edge
    task automatic drive_step(input logic v, input logic b, input sample_t d);
        @(posedge clk);
        valid_in  <= v;
        bypass    <= b;
        filter_in <= d;
        @(negedge clk);
        check_value("valid_out", exp_valid, valid_out);
        check_value("filter_out", exp_value, filter_out);
        check_value("overflow", exp_ovf, overflow);
        check_value("underflow", exp_unf, underflow);
        if (valid_out) begin
            out_count++;
        end
        model_update(v, b, d);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n     <= 1'b0;
        valid_in  <= 1'b0;
        bypass    <= 1'b0;
        filter_in <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        for (int k = 0; k < PHASE_TAPS; k++) begin
            hist[k] = 0;
        end
        phase_cnt = 0;
        exp_valid = 1'b0;
        exp_value = '0;
        exp_ovf   = 1'b0;
        exp_unf   = 1'b0;
        out_count = 0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        test_name = "reset state";
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_value("valid_out in reset", 0, valid_out);
        check_value("filter_out in reset", 0, filter_out);
        check_value("overflow in reset", 0, overflow);
        check_value("underflow in reset", 0, underflow);
        apply_reset();
        drive_step(1'b0, 1'b0, '0);
    endtask

    task automatic test_decimation_pattern();
        test_name = "decimation pattern";
        apply_reset();
        for (int i = 0; i < 30; i++) begin
            rng_state = xorshift32(rng_state);
            drive_step(1'b1, 1'b0, sample_t'(rng_state[31:16] >> 2));
        end
        drive_step(1'b0, 1'b0, '0);
        check_value("output count", 20, out_count);
        // Same pattern with an idle cycle after every sample
        out_count = 0;
        for (int i = 0; i < 30; i++) begin
            rng_state = xorshift32(rng_state);
            drive_step(1'b1, 1'b0, sample_t'(rng_state[31:16] >> 2));
            drive_step(1'b0, 1'b0, '0);
        end
        check_value("output count with gaps", 20, out_count);
    endtask

    task automatic test_impulse();
        test_name = "impulse response";
        apply_reset();
        drive_step(1'b1, 1'b0, 16'sd16384);
        for (int i = 0; i < 14; i++) begin
            drive_step(1'b1, 1'b0, '0);
        end
        drive_step(1'b0, 1'b0, '0);
    endtask

    task automatic test_random_data();
        test_name = "random data";
        apply_reset();
        for (int i = 0; i < 60; i++) begin
            rng_state = xorshift32(rng_state);
            drive_step(rng_state[1:0] != 2'b00, 1'b0, sample_t'(rng_state[31:16]));
        end
        drive_step(1'b0, 1'b0, '0);
    endtask

    task automatic test_saturation();
        int      idx;
        logic    pos;
        sample_t s;
        test_name = "saturation";
        for (int dir = 0; dir < 2; dir++) begin
            apply_reset();
            // Samples 3 to 10 land on taps 7 to 0 when sample 11 hits phase A
            for (int e = 1; e <= 10; e++) begin
                idx = 10 - e;
                s   = '0;
                if (e >= 3) begin
                    pos = ($signed(COEFF_PHASE_A[idx]) > 0) ^ (dir == 1);
                    s   = pos ? 16'sd32767 : -16'sd32768;
                end
                drive_step(1'b1, 1'b0, s);
            end
            drive_step(1'b1, 1'b0, '0);
            drive_step(1'b0, 1'b0, '0);
            check_value("saturated value", (dir == 0) ? 32767 : -32768, filter_out);
            check_value("overflow flag", (dir == 0) ? 1 : 0, overflow);
            check_value("underflow flag", (dir == 0) ? 0 : 1, underflow);
        end
    endtask

    task automatic test_bypass();
        test_name = "bypass";
        apply_reset();
        for (int i = 0; i < 12; i++) begin
            rng_state = xorshift32(rng_state);
            drive_step(rng_state[2:0] != 3'b000, 1'b1, sample_t'(rng_state[31:16]));
        end
        for (int i = 0; i < 20; i++) begin
            rng_state = xorshift32(rng_state);
            drive_step(1'b1, 1'b0, sample_t'(rng_state[31:16]));
        end
        drive_step(1'b0, 1'b0, '0);
    endtask

    initial begin
        rst_n       = 1'b0;
        valid_in    = 1'b0;
        bypass      = 1'b0;
        filter_in   = '0;
        error_count = 0;
        check_count = 0;
        out_count   = 0;
        rng_state   = 32'd90;

        test_reset_state();
        test_decimation_pattern();
        test_impulse();
        test_random_data();
        test_saturation();
        test_bypass();

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
src/decim_pkg.sv
src/decim_phase_fsm.sv
src/tap_delay_line.sv
src/polyphase_mac.sv
src/output_quantizer.sv
src/fractional_decimator.sv
dv/fractional_decimator_tb.sv

// ==== Bender.yml ====
package:
  name: fractional_decimator

sources:
  - files:
      - src/decim_pkg.sv
      - src/decim_phase_fsm.sv
      - src/tap_delay_line.sv
      - src/polyphase_mac.sv
      - src/output_quantizer.sv
      - src/fractional_decimator.sv
  - target: simulation
    files:
      - dv/fractional_decimator_tb.sv
